// File: include/dispatch_consts.svh
`ifndef DISPATCH_CONSTS_SVH
`define DISPATCH_CONSTS_SVH

// datapath widths
`define DATA_W 32
`define PREG_W 6
`define AREG_W 5
`define ROB_W 5
`define PC_W 32

// unit class codes, 2'b00 is unused
`define ALU_TYPE 2'd1
`define LSU_TYPE 2'd2
`define MDU_TYPE 2'd3

// issue queue geometry
`define IQ_DEPTH 8
`define IQ_NUM 4
`define IQ_ID_W 2

// queue indices
`define IQ_ALU0 0
`define IQ_ALU1 1
`define IQ_LSU 2
`define IQ_MDU 3

`endif

// File: hw/dispatch_pkg.sv
`include "dispatch_consts.svh"

package dispatch_pkg;

    typedef logic [`DATA_W-1:0] word_t;
    typedef logic [`PREG_W-1:0] preg_t;
    typedef logic [`AREG_W-1:0] areg_t;
    typedef logic [`ROB_W-1:0]  rob_id_t;
    typedef logic [1:0]         itype_t;

    // one instruction as handed over by rename
    typedef struct packed {
        logic               r_valid;
        itype_t             inst_type;
        areg_t              areg;
        preg_t              preg;
        logic               w_reg;
        logic               w_mem;
        logic [`PC_W-1:0]   pc;
        rob_id_t            rob_id;
        preg_t [1:0]        src_preg;
        logic  [1:0]        use_imm;
        // arf data already good for this source
        logic  [1:0]        data_valid;
        word_t [1:0]        arf_data;
        word_t              data_imm;
    } rename_slot_t;

    typedef struct packed {
        logic   w_reg;
        preg_t  w_preg;
        word_t  w_data;
    } cdb_t;

    typedef struct packed {
        logic   rob_complete;
        word_t  rob_data;
    } rob_read_t;

    // allocation view sent to the rob
    typedef struct packed {
        logic               issue;
        itype_t             inst_type;
        areg_t              areg;
        preg_t              preg;
        preg_t [1:0]        src_preg;
        logic [`PC_W-1:0]   pc;
        logic               w_reg;
        logic               w_mem;
        rob_id_t            rob_id;
    } dispatch_rob_t;

    typedef struct packed {
        rob_id_t            rob_id;
        preg_t              preg;
        itype_t             inst_type;
        logic  [1:0]        src_ready;
        preg_t [1:0]        src_preg;
        word_t [1:0]        src_data;
    } iq_entry_t;

    typedef struct packed {
        logic                   valid;
        logic [`IQ_ID_W-1:0]    iq_id;
        rob_id_t                rob_id;
        preg_t                  preg;
        word_t [1:0]            src_data;
    } issue_t;

endpackage

// File: hw/p_dispatch.sv
`timescale 1ns/1ps
`include "dispatch_consts.svh"

module p_dispatch import dispatch_pkg::*; (
    input  rename_slot_t  [1:0]              rename_i,
    input  logic                             rename_valid_i,
    output logic                             rename_ready_o,
    input  cdb_t          [1:0]              cdb_i,
    input  rob_read_t     [3:0]              rob_read_i,
    input  logic                             flush_i,
    input  logic          [`IQ_NUM-1:0]      iq_free2_i,
    output dispatch_rob_t [1:0]              dispatch_rob_o,
    output logic          [`IQ_NUM-1:0][1:0] iq_wr_en_o,
    output iq_entry_t     [`IQ_NUM-1:0][1:0] iq_wr_o
);

    logic            accept;
    logic [3:0]      cdb_hit;
    word_t [3:0]     cdb_data;
    logic [3:0]      opnd_ready;
    word_t [3:0]     opnd_data;
    iq_entry_t [1:0] entry;

    // every queue must take a full pair
    assign rename_ready_o = (&iq_free2_i) & ~flush_i;
    assign accept         = rename_valid_i & rename_ready_o;

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            dispatch_rob_o[i].issue     = rename_i[i].r_valid & accept;
            dispatch_rob_o[i].inst_type = rename_i[i].inst_type;
            dispatch_rob_o[i].areg      = rename_i[i].areg;
            dispatch_rob_o[i].preg      = rename_i[i].preg;
            dispatch_rob_o[i].src_preg  = rename_i[i].src_preg;
            dispatch_rob_o[i].pc        = rename_i[i].pc;
            dispatch_rob_o[i].w_reg     = rename_i[i].w_reg;
            dispatch_rob_o[i].w_mem     = rename_i[i].w_mem;
            dispatch_rob_o[i].rob_id    = rename_i[i].rob_id;
        end
    end

    // source s belongs to slot s/2, operand s%2
    always_comb begin
        for (int s = 0; s < 4; s++) begin
            cdb_hit[s]  = 1'b0;
            cdb_data[s] = '0;
            for (int p = 0; p < 2; p++) begin
                if (cdb_i[p].w_reg && cdb_i[p].w_preg == rename_i[s / 2].src_preg[s % 2]) begin
                    cdb_hit[s]  = 1'b1;
                    cdb_data[s] = cdb_i[p].w_data;
                end
            end
        end
    end

    // arf/imm first, then same-cycle cdb, then rob
    always_comb begin
        for (int s = 0; s < 4; s++) begin
            if (rename_i[s / 2].data_valid[s % 2]) begin
                opnd_ready[s] = 1'b1;
                opnd_data[s]  = rename_i[s / 2].use_imm[s % 2] ? rename_i[s / 2].data_imm
                                                               : rename_i[s / 2].arf_data[s % 2];
            end else if (cdb_hit[s]) begin
                opnd_ready[s] = 1'b1;
                opnd_data[s]  = cdb_data[s];
            end else begin
                opnd_ready[s] = rob_read_i[s].rob_complete;
                opnd_data[s]  = rob_read_i[s].rob_data;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            entry[i].rob_id    = rename_i[i].rob_id;
            entry[i].preg      = rename_i[i].preg;
            entry[i].inst_type = rename_i[i].inst_type;
            entry[i].src_preg  = rename_i[i].src_preg;
            entry[i].src_ready = opnd_ready[i * 2 +: 2];
            entry[i].src_data  = {opnd_data[i * 2 + 1], opnd_data[i * 2]};
        end
    end

    // alu split by destination parity, lsu/mdu take both slots
    always_comb begin
        iq_wr_en_o = '0;
        for (int i = 0; i < 2; i++) begin
            if (accept && rename_i[i].r_valid) begin
                case (rename_i[i].inst_type)
                    `ALU_TYPE: begin
                        if (rename_i[i].preg[0]) begin
                            iq_wr_en_o[`IQ_ALU1][i] = 1'b1;
                        end else begin
                            iq_wr_en_o[`IQ_ALU0][i] = 1'b1;
                        end
                    end
                    `LSU_TYPE: iq_wr_en_o[`IQ_LSU][i] = 1'b1;
                    `MDU_TYPE: iq_wr_en_o[`IQ_MDU][i] = 1'b1;
                    default: ;
                endcase
            end
        end
    end

    // all queues see the same pair, enables pick
    always_comb begin
        for (int q = 0; q < `IQ_NUM; q++) begin
            iq_wr_o[q] = entry;
        end
    end

endmodule

// File: hw/issue_queue.sv
`timescale 1ns/1ps
`include "dispatch_consts.svh"

module issue_queue import dispatch_pkg::*; (
    input  logic            clk,
    input  logic            arst_n_i,
    input  logic            flush_i,
    input  logic      [1:0] wr_en_i,
    input  iq_entry_t [1:0] wr_i,
    input  cdb_t      [1:0] cdb_i,
    input  logic            pop_i,
    output logic            free2_o,
    output logic            head_valid_o,
    output iq_entry_t       head_o
);

    localparam int PTR_W = $clog2(`IQ_DEPTH);
    localparam int CNT_W = $clog2(`IQ_DEPTH + 1);

    iq_entry_t        mem_q [`IQ_DEPTH];
    logic [PTR_W-1:0] head_q;
    logic [PTR_W-1:0] tail_q;
    logic [CNT_W-1:0] count_q;
    logic [PTR_W-1:0] wr_ptr1;
    logic [CNT_W-1:0] n_wr;
    logic             do_pop;

    // only the oldest entry may go
    assign head_o       = mem_q[head_q];
    assign head_valid_o = (count_q != '0) && (&head_o.src_ready);
    assign do_pop       = pop_i && head_valid_o;

    assign free2_o = count_q <= CNT_W'(`IQ_DEPTH - 2);

    // slot 1 lands behind slot 0 when both write
    assign wr_ptr1 = tail_q + PTR_W'(wr_en_i[0]);
    assign n_wr    = CNT_W'(wr_en_i[0]) + CNT_W'(wr_en_i[1]);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (flush_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            tail_q  <= tail_q + PTR_W'(n_wr);
            head_q  <= head_q + PTR_W'(do_pop);
            count_q <= count_q + n_wr - CNT_W'(do_pop);
        end
    end

    // wake-up on either cdb port, ready the cycle after
    always_ff @(posedge clk) begin
        for (int i = 0; i < `IQ_DEPTH; i++) begin
            for (int k = 0; k < 2; k++) begin
                for (int p = 0; p < 2; p++) begin
                    if (!mem_q[i].src_ready[k] && cdb_i[p].w_reg &&
                        cdb_i[p].w_preg == mem_q[i].src_preg[k]) begin
                        mem_q[i].src_ready[k] <= 1'b1;
                        mem_q[i].src_data[k]  <= cdb_i[p].w_data;
                    end
                end
            end
        end
        // new entries go into free slots only
        if (wr_en_i[0]) begin
            mem_q[tail_q] <= wr_i[0];
        end
        if (wr_en_i[1]) begin
            mem_q[wr_ptr1] <= wr_i[1];
        end
    end

endmodule

// File: hw/issue_arbiter.sv
`timescale 1ns/1ps
`include "dispatch_consts.svh"

module issue_arbiter import dispatch_pkg::*; (
    input  logic                          clk,
    input  logic                          arst_n_i,
    input  logic                          flush_i,
    input  logic      [`IQ_NUM-1:0]       head_valid_i,
    input  iq_entry_t [`IQ_NUM-1:0]       head_i,
    output logic      [`IQ_NUM-1:0]       pop_o,
    output issue_t    [1:0]               issue_o
);

    localparam int QID_W = `IQ_ID_W;

    logic [QID_W-1:0]      rr_q;
    logic [QID_W-1:0]      rr_d;
    logic [1:0][QID_W-1:0] port_sel;
    logic [1:0]            port_vld;
    logic [1:0]            vld_q;
    issue_t [1:0]          issue_d;
    issue_t [1:0]          pay_q;

    // scan from the pointer, first two ready heads win
    always_comb begin
        logic [QID_W-1:0] idx;
        logic [1:0]       n_grant;
        pop_o    = '0;
        port_sel = '0;
        port_vld = '0;
        rr_d     = rr_q;
        n_grant  = '0;
        for (int i = 0; i < `IQ_NUM; i++) begin
            idx = rr_q + QID_W'(i);
            if (head_valid_i[idx] && n_grant < 2'd2 && !flush_i) begin
                pop_o[idx]            = 1'b1;
                port_sel[n_grant[0]] = idx;
                port_vld[n_grant[0]] = 1'b1;
                rr_d                  = idx + 1'b1;
                n_grant               = n_grant + 2'd1;
            end
        end
    end

    always_comb begin
        for (int p = 0; p < 2; p++) begin
            issue_d[p].valid    = port_vld[p];
            issue_d[p].iq_id    = port_sel[p];
            issue_d[p].rob_id   = head_i[port_sel[p]].rob_id;
            issue_d[p].preg     = head_i[port_sel[p]].preg;
            issue_d[p].src_data = head_i[port_sel[p]].src_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rr_q  <= '0;
            vld_q <= '0;
        end else begin
            rr_q  <= rr_d;
            vld_q <= port_vld;
        end
    end

    always_ff @(posedge clk) begin
        pay_q <= issue_d;
    end

    always_comb begin
        issue_o = pay_q;
        for (int p = 0; p < 2; p++) begin
            issue_o[p].valid = vld_q[p];
        end
    end

endmodule

// File: hw/backend_issue_top.sv
`timescale 1ns/1ps
`include "dispatch_consts.svh"

module backend_issue_top import dispatch_pkg::*; (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic                  flush_i,
    input  rename_slot_t  [1:0]   rename_i,
    input  logic                  rename_valid_i,
    output logic                  rename_ready_o,
    input  cdb_t          [1:0]   cdb_i,
    input  rob_read_t     [3:0]   rob_read_i,
    output dispatch_rob_t [1:0]   dispatch_rob_o,
    output issue_t        [1:0]   issue_o
);

    logic      [`IQ_NUM-1:0]       iq_free2;
    logic      [`IQ_NUM-1:0][1:0]  iq_wr_en;
    iq_entry_t [`IQ_NUM-1:0][1:0]  iq_wr;
    logic      [`IQ_NUM-1:0]       head_valid;
    iq_entry_t [`IQ_NUM-1:0]       head;
    logic      [`IQ_NUM-1:0]       pop;

    p_dispatch i_p_dispatch (
        .rename_i       (rename_i),
        .rename_valid_i (rename_valid_i),
        .rename_ready_o (rename_ready_o),
        .cdb_i          (cdb_i),
        .rob_read_i     (rob_read_i),
        .flush_i        (flush_i),
        .iq_free2_i     (iq_free2),
        .dispatch_rob_o (dispatch_rob_o),
        .iq_wr_en_o     (iq_wr_en),
        .iq_wr_o        (iq_wr)
    );

    // alu0, alu1, lsu, mdu
    for (genvar q = 0; q < `IQ_NUM; q++) begin : g_iq
        issue_queue i_issue_queue (
            .clk          (clk),
            .arst_n_i     (arst_n_i),
            .flush_i      (flush_i),
            .wr_en_i      (iq_wr_en[q]),
            .wr_i         (iq_wr[q]),
            .cdb_i        (cdb_i),
            .pop_i        (pop[q]),
            .free2_o      (iq_free2[q]),
            .head_valid_o (head_valid[q]),
            .head_o       (head[q])
        );
    end

    issue_arbiter i_issue_arbiter (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .flush_i      (flush_i),
        .head_valid_i (head_valid),
        .head_i       (head),
        .pop_o        (pop),
        .issue_o      (issue_o)
    );

endmodule

// File: test/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// one accepted instruction as the checker expects it
typedef struct packed {
    rob_id_t      rob_id;
    preg_t        preg;
    logic [1:0]   data_valid;
    logic [1:0]   use_imm;
    preg_t [1:0]  src_preg;
    word_t [1:0]  arf_data;
    word_t        data_imm;
} exp_t;

// value and broadcast state per physical register
word_t       preg_val [64];
logic        preg_done [64];
logic [31:0] lfsr_q = 32'h55ca_b8fb;

// fibonacci lfsr, taps 32 22 2 1
function automatic logic lfsr_step();
    logic fb;
    fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
endfunction

function automatic logic [31:0] rand_bits(int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
        r = {r[30:0], lfsr_step()};
    end
    return r;
endfunction

// expected operand: arf or imm when data is good, else the producer's value
function automatic word_t ref_operand(exp_t e, int k);
    if (e.data_valid[k]) begin
        return e.use_imm[k] ? e.data_imm : e.arf_data[k];
    end
    return preg_val[e.src_preg[k]];
endfunction

function automatic word_t result_value(word_t a, word_t b, rob_id_t id);
    return a + b + word_t'(id);
endfunction

// alu by destination parity, lsu and mdu have their own queue
function automatic int iq_route(rename_slot_t s);
    if (s.inst_type == `LSU_TYPE) begin
        return `IQ_LSU;
    end
    if (s.inst_type == `MDU_TYPE) begin
        return `IQ_MDU;
    end
    return s.preg[0] ? `IQ_ALU1 : `IQ_ALU0;
endfunction

function automatic exp_t to_exp(rename_slot_t s);
    exp_t e;
    e.rob_id     = s.rob_id;
    e.preg       = s.preg;
    e.data_valid = s.data_valid;
    e.use_imm    = s.use_imm;
    e.src_preg   = s.src_preg;
    e.arf_data   = s.arf_data;
    e.data_imm   = s.data_imm;
    return e;
endfunction

`endif

// File: test/tb_backend_issue.sv
`timescale 1ns/1ps
`include "dispatch_consts.svh"

module tb_backend_issue import dispatch_pkg::*; ();

    logic                 clk;
    logic                 arst_n_i;
    logic                 flush_i;
    rename_slot_t  [1:0]  rename_i;
    logic                 rename_valid_i;
    logic                 rename_ready_o;
    cdb_t          [1:0]  cdb_i;
    rob_read_t     [3:0]  rob_read_i;
    dispatch_rob_t [1:0]  dispatch_rob_o;
    issue_t        [1:0]  issue_o;

    `include "tb_ref_model.svh"

    exp_t               exp_q [`IQ_NUM][$];
    preg_t              produced [$];
    rename_slot_t [1:0] rn_cur;
    logic               rn_vld;
    logic               flush_r;
    logic               echo_v [4][2];
    preg_t              echo_preg [4][2];
    word_t              echo_data [4][2];
    int                 cyc;
    int                 pairs_left;
    int                 gen_mode;
    int                 next_preg;
    rob_id_t            next_rob;
    int                 n_checks;
    int                 n_errors;
    int                 n_tests;
    int                 err_base;
    int                 flush_base;

    backend_issue_top i_backend_issue_top (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .flush_i        (flush_i),
        .rename_i       (rename_i),
        .rename_valid_i (rename_valid_i),
        .rename_ready_o (rename_ready_o),
        .cdb_i          (cdb_i),
        .rob_read_i     (rob_read_i),
        .dispatch_rob_o (dispatch_rob_o),
        .issue_o        (issue_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic report_mismatch(string name, logic [127:0] got, logic [127:0] exp);
        n_errors++;
        $display("[FAIL] %0t %s got %0h expected %0h", $time, name, got, exp);
    endtask

    task automatic report_error(string what);
        n_errors++;
        $display("[FAIL] %0t %s", $time, what);
    endtask

    task automatic abort_run(string why);
        n_errors++;
        $display("timeout: %s", why);
        $display("** FAIL **");
        $finish;
    endtask

    task automatic make_slot(int i);
        rename_slot_t s;
        logic [1:0]   m;
        logic         dep;
        s           = '0;
        s.r_valid   = rand_bits(3) != 0;
        m           = rand_bits(2);
        s.inst_type = (m == 2'd2) ? `LSU_TYPE : (m == 2'd3) ? `MDU_TYPE : `ALU_TYPE;
        s.preg      = preg_t'(next_preg);
        s.areg      = rand_bits(5);
        s.w_reg     = 1'b1;
        s.w_mem     = s.inst_type == `LSU_TYPE;
        s.pc        = rand_bits(32);
        s.rob_id    = next_rob;
        s.data_imm  = rand_bits(32);
        next_preg++;
        next_rob++;
        for (int k = 0; k < 2; k++) begin
            m   = rand_bits(2);
            dep = (gen_mode == 2) || (gen_mode == 1 ? m != 0 : m[1]);
            if (dep && gen_mode == 2) begin
                s.src_preg[k] = 6'd63;
            end else if (dep && produced.size() > 0) begin
                s.src_preg[k] = produced[rand_bits(6) % produced.size()];
            end else begin
                s.data_valid[k] = 1'b1;
                s.use_imm[k]    = m[0];
                s.arf_data[k]   = rand_bits(32);
            end
        end
        if (s.r_valid) begin
            produced.push_back(s.preg);
        end
        rn_cur[i] = s;
    endtask

    // one rising edge of cdb echo, handshake and new stimulus
    task automatic cycle_edge();
        cdb_t      [1:0] cdb_d;
        rob_read_t [3:0] rr;
        int              slot;
        rename_slot_t    sl;
        preg_t           src;
        @(posedge clk);
        cyc++;
        slot = cyc % 4;
        for (int p = 0; p < 2; p++) begin
            cdb_d[p] = '0;
            if (echo_v[slot][p]) begin
                cdb_d[p].w_reg  = 1'b1;
                cdb_d[p].w_preg = echo_preg[slot][p];
                cdb_d[p].w_data = echo_data[slot][p];
                preg_val[echo_preg[slot][p]]  = echo_data[slot][p];
                preg_done[echo_preg[slot][p]] = 1'b1;
                echo_v[slot][p] = 1'b0;
            end
        end
        if (rn_vld && rename_ready_o) begin
            for (int i = 0; i < 2; i++) begin
                if (rn_cur[i].r_valid) begin
                    exp_q[iq_route(rn_cur[i])].push_back(to_exp(rn_cur[i]));
                end
            end
            rn_vld = 1'b0;
        end
        if (!rn_vld && pairs_left > 0) begin
            make_slot(0);
            make_slot(1);
            pairs_left--;
            rn_vld = 1'b1;
        end
        // the rob holds a result only from the cycle after its broadcast
        for (int s = 0; s < 4; s++) begin
            sl  = rn_cur[s / 2];
            src = sl.src_preg[s % 2];
            rr[s].rob_complete = !sl.data_valid[s % 2] && preg_done[src]
                                 && !(cdb_d[0].w_reg && cdb_d[0].w_preg == src)
                                 && !(cdb_d[1].w_reg && cdb_d[1].w_preg == src);
            rr[s].rob_data     = rr[s].rob_complete ? preg_val[src]
                                                    : word_t'(32'hdead_0000 + s);
        end
        cdb_i          <= cdb_d;
        rename_i       <= rn_cur;
        rename_valid_i <= rn_vld;
        rob_read_i     <= rr;
        flush_i        <= flush_r;
    endtask

    task automatic wait_sent(int lim);
        int n;
        n = 0;
        while ((pairs_left > 0 || rn_vld) && n < lim) begin
            cycle_edge();
            n++;
        end
        if (pairs_left > 0 || rn_vld) begin
            abort_run("rename pairs were not accepted");
        end
    endtask

    function automatic logic busy();
        logic b;
        b = 1'b0;
        for (int q = 0; q < `IQ_NUM; q++) begin
            b |= exp_q[q].size() != 0;
        end
        for (int s = 0; s < 4; s++) begin
            b |= echo_v[s][0] | echo_v[s][1];
        end
        return b;
    endfunction

    task automatic drain(int lim);
        int n;
        n = 0;
        while (busy() && n < lim) begin
            cycle_edge();
            n++;
        end
        if (busy()) begin
            abort_run("queues did not drain");
        end
    endtask

    task automatic new_test(int mode, int pairs);
        produced.delete();
        for (int i = 0; i < 64; i++) begin
            preg_done[i] = 1'b0;
        end
        next_preg  = 1;
        gen_mode   = mode;
        pairs_left = pairs;
        err_base   = n_errors;
    endtask

    task automatic end_test(string name);
        n_tests++;
        $display("test %-12s %s", name, (n_errors == err_base) ? "ok" : "errors");
    endtask

    // checker at the falling edge where outputs are settled
    always @(negedge clk) begin
        dispatch_rob_t exp_rob;
        exp_t          e;
        word_t [1:0]   opnd;
        int            q;
        logic          exp_ready;
        if (arst_n_i) begin
            for (int p = 0; p < 2; p++) begin
                if (issue_o[p].valid) begin
                    q = issue_o[p].iq_id;
                    n_checks++;
                    assert (exp_q[q].size() != 0) else
                        report_error($sformatf("port %0d issued from empty queue %0d", p, q));
                    if (exp_q[q].size() != 0) begin
                        e = exp_q[q].pop_front();
                        assert (issue_o[p].rob_id == e.rob_id) else
                            report_mismatch("issue_o.rob_id", issue_o[p].rob_id, e.rob_id);
                        assert (issue_o[p].preg == e.preg) else
                            report_mismatch("issue_o.preg", issue_o[p].preg, e.preg);
                        for (int k = 0; k < 2; k++) begin
                            assert (e.data_valid[k] || preg_done[e.src_preg[k]]) else
                                report_error("instruction issued before its source was broadcast");
                            opnd[k] = ref_operand(e, k);
                            assert (issue_o[p].src_data[k] == opnd[k]) else
                                report_mismatch("issue_o.src_data", issue_o[p].src_data[k], opnd[k]);
                        end
                        echo_v[(cyc + 3) % 4][p]    = 1'b1;
                        echo_preg[(cyc + 3) % 4][p] = e.preg;
                        echo_data[(cyc + 3) % 4][p] = result_value(opnd[0], opnd[1], e.rob_id);
                    end
                end
            end
            // after this cycle's issues the model holds what each queue holds
            exp_ready = !flush_i;
            for (int i = 0; i < `IQ_NUM; i++) begin
                if (exp_q[i].size() > `IQ_DEPTH - 2) begin
                    exp_ready = 1'b0;
                end
            end
            n_checks++;
            assert (rename_ready_o == exp_ready) else
                report_mismatch("rename_ready_o", rename_ready_o, exp_ready);
            for (int i = 0; i < 2; i++) begin
                exp_rob.issue     = rn_cur[i].r_valid && rn_vld && exp_ready;
                exp_rob.inst_type = rn_cur[i].inst_type;
                exp_rob.areg      = rn_cur[i].areg;
                exp_rob.preg      = rn_cur[i].preg;
                exp_rob.src_preg  = rn_cur[i].src_preg;
                exp_rob.pc        = rn_cur[i].pc;
                exp_rob.w_reg     = rn_cur[i].w_reg;
                exp_rob.w_mem     = rn_cur[i].w_mem;
                exp_rob.rob_id    = rn_cur[i].rob_id;
                n_checks++;
                assert (dispatch_rob_o[i] == exp_rob) else
                    report_mismatch($sformatf("dispatch_rob_o[%0d]", i), dispatch_rob_o[i],
                                    exp_rob);
            end
        end
    end

    initial begin
        arst_n_i       = 1'b0;
        flush_i        = 1'b0;
        rename_i       = '0;
        rename_valid_i = 1'b0;
        cdb_i          = '0;
        rob_read_i     = '0;
        rn_cur         = '0;
        rn_vld         = 1'b0;
        flush_r        = 1'b0;
        cyc            = 0;
        pairs_left     = 0;
        next_rob       = '0;
        n_checks       = 0;
        n_errors       = 0;
        n_tests        = 0;
        flush_base     = 0;
        for (int s = 0; s < 4; s++) begin
            echo_v[s][0] = 1'b0;
            echo_v[s][1] = 1'b0;
        end
        new_test(0, 0);
        repeat (16) @(posedge clk);
        arst_n_i <= 1'b1;
        repeat (2) cycle_edge();
        n_checks += 2;
        assert (rename_ready_o) else report_mismatch("rename_ready_o", rename_ready_o, 1);
        assert (!issue_o[0].valid && !issue_o[1].valid) else
            report_error("issue valid set after reset");
        end_test("reset");

        new_test(0, 16);
        wait_sent(400);
        drain(400);
        end_test("random_mix");

        new_test(1, 16);
        wait_sent(400);
        drain(400);
        end_test("dep_chains");

        // entries wait on a preg nobody writes and get flushed
        new_test(2, 3);
        wait_sent(100);
        repeat (4) cycle_edge();
        flush_r = 1'b1;
        cycle_edge();
        flush_r = 1'b0;
        cycle_edge();
        for (int q = 0; q < `IQ_NUM; q++) begin
            exp_q[q].delete();
        end
        repeat (20) cycle_edge();
        n_checks++;
        assert (rename_ready_o) else report_mismatch("rename_ready_o", rename_ready_o, 1);
        flush_base = err_base;
        new_test(0, 4);
        err_base = flush_base;
        wait_sent(100);
        drain(200);
        end_test("flush");

        $display("tests %0d checks %0d errors %0d", n_tests, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: filelist.f
+incdir+include
+incdir+test
hw/dispatch_pkg.sv
hw/p_dispatch.sv
hw/issue_queue.sv
hw/issue_arbiter.sv
hw/backend_issue_top.sv
test/tb_backend_issue.sv

// File: run.sh
#!/bin/sh
# build and run the testbench with verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal \
    -f filelist.f \
    --top-module tb_backend_issue \
    -o sim_tb \
    && ./obj_dir/sim_tb | tee /dev/stderr | grep -qx '\*\* PASS \*\*' \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
